// File: tb.f
design/cpu_line_pkg.sv
design/ddr_app_pkg.sv
design/line_sequencer.sv
design/read_assembler.sv
design/bridge_csr.sv
design/ddr_line_bridge.sv
tests/app_mem_model.sv
tests/tb_ddr_line_bridge.sv

// File: Bender.yml
package:
  name: ddr_line_bridge

sources:
  - files:
      - design/cpu_line_pkg.sv
      - design/ddr_app_pkg.sv
      - design/line_sequencer.sv
      - design/read_assembler.sv
      - design/bridge_csr.sv
      - design/ddr_line_bridge.sv
  - target: test
    files:
      - tests/app_mem_model.sv
      - tests/tb_ddr_line_bridge.sv

// File: tests/tb_ddr_line_bridge.sv
// DDR line bridge testbench
`timescale 1ns/1ps

module tb_ddr_line_bridge;

    localparam int N_RAND  = 200;
    localparam int TIMEOUT = 400 * (N_RAND + 3) + 2000;

    logic                    ui_clk;
    logic                    rst;
    cpu_line_pkg::line_req_t req;
    logic                    req_valid;
    logic                    req_ready;
    cpu_line_pkg::line_rsp_t rsp;
    logic                    rsp_valid;
    logic                    rsp_ready;
    cpu_line_pkg::csr_req_t  csr;
    logic                    csr_valid;
    logic                    csr_ready;
    cpu_line_pkg::csr_data_t csr_rdata;
    logic                    csr_rvalid;
    ddr_app_pkg::app_req_t   app_cmd_req;
    logic                    app_en;
    logic                    app_rdy;
    ddr_app_pkg::app_data_t  app_wdf_data;
    logic                    app_wdf_wren;
    logic                    app_wdf_end;
    logic                    app_wdf_rdy;
    ddr_app_pkg::app_data_t  app_rd_data;
    logic                    app_rd_data_valid;
    logic                    init_calib_complete;
    logic                    rdy_stall;
    logic                    wdf_stall;
    logic [2:0]              rd_lat;

    logic [31:0]              lfsr = 32'h689b_6569;
    cpu_line_pkg::line_data_t shadow [cpu_line_pkg::line_addr_t];
    cpu_line_pkg::line_data_t exp_rsp_q [$];
    ddr_app_pkg::app_addr_t   exp_addr_q [$];
    ddr_app_pkg::app_data_t   exp_wdata_q [$];
    ddr_app_pkg::app_addr_t   base;
    ddr_app_pkg::app_data_t   beat_exp;
    cpu_line_pkg::csr_data_t  val;
    cpu_line_pkg::line_addr_t line;
    logic                     is_wr;
    logic                     ctrl_on = 1'b0;
    int                       wr_accepted = 0;
    int                       rd_taken = 0;
    int                       data_errs = 0;
    int                       addr_errs = 0;
    int                       csr_errs = 0;
    int                       other_errs = 0;
    int                       cycles = 0;

    ddr_line_bridge #(.CNT_W(16)) UUT (.*);
    app_mem_model u_mem (.*);

    initial begin
        ui_clk = 1'b0;
        forever #50 ui_clk = ~ui_clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    // Galois LFSR x^32 + x^22 + x^2 + x + 1
    // One step per bit taken
    function automatic logic [255:0] rand_bits(input int n);
        logic [255:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            v = {v[254:0], lfsr[0]};
        end
        return v;
    endfunction

    // Expected line for a read
    // Lines never written read as zero
    function automatic cpu_line_pkg::line_data_t expected_line(
        input cpu_line_pkg::line_addr_t l);
        return shadow.exists(l) ? shadow[l] : '0;
    endfunction

    task automatic check_line(input string name, input cpu_line_pkg::line_data_t exp, act);
        if (act !== exp) begin
            data_errs++;
            $display("error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_beat(input string name, input ddr_app_pkg::app_data_t exp, act);
        if (act !== exp) begin
            data_errs++;
            $display("error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_app_addr(input string name, input ddr_app_pkg::app_addr_t exp, act);
        if (act !== exp) begin
            addr_errs++;
            $display("error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_csr(input string name, input cpu_line_pkg::csr_data_t exp, act);
        if (act !== exp) begin
            csr_errs++;
            $display("error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic send_req(input logic wr, input cpu_line_pkg::line_addr_t l,
                            input cpu_line_pkg::line_data_t d);
        req.write <= wr;
        req.addr  <= l;
        req.data  <= d;
        req_valid <= 1'b1;
        do @(posedge ui_clk); while (!req_ready);
        req_valid <= 1'b0;
    endtask

    task automatic csr_access(input logic wr, input cpu_line_pkg::csr_addr_t a,
                              input cpu_line_pkg::csr_data_t wd,
                              output cpu_line_pkg::csr_data_t rd);
        csr.write <= wr;
        csr.addr  <= a;
        csr.data  <= wd;
        csr_valid <= 1'b1;
        do @(posedge ui_clk); while (!csr_ready);
        csr_valid <= 1'b0;
        rd = '0;
        if (!wr) begin
            do @(posedge ui_clk); while (!csr_rvalid);
            rd = csr_rdata;
        end
    endtask

    task automatic finish_run();
        $display("Error counts: data %0d, address %0d, csr %0d, other %0d",
                 data_errs, addr_errs, csr_errs, other_errs);
        if (data_errs + addr_errs + csr_errs + other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    // ------------------------------
    // Environment and monitors
    // ------------------------------

    // Ready stalls, read latency and response back-pressure
    always @(posedge ui_clk) begin
        rdy_stall <= (rand_bits(2) == 0);
        wdf_stall <= (rand_bits(2) == 0);
        rd_lat    <= 3'(rand_bits(3));
        rsp_ready <= (rand_bits(2) != 0);
    end

    always @(posedge ui_clk) begin
        if (rst && !ctrl_on && (req_ready || app_en)) begin
            other_errs++;
            $display("Bridge accepted a request or issued a command while disabled");
        end
    end

    // Beat addresses and write halves against the mapping rule
    always @(posedge ui_clk) begin
        if (rst && app_en && app_rdy && (!app_wdf_wren || app_wdf_rdy)) begin
            if (exp_addr_q.size() == 0) begin
                other_errs++;
                $display("Command issued with no request pending");
            end else begin
                check_app_addr("app_cmd_req.addr", exp_addr_q.pop_front(), app_cmd_req.addr);
                beat_exp = exp_wdata_q.pop_front();
                if (app_wdf_wren) begin
                    check_beat("app_wdf_data", beat_exp, app_wdf_data);
                end
            end
        end
        if (rst && req_valid && req_ready) begin
            base = ddr_app_pkg::app_addr_t'(req.addr) * 32;
            exp_addr_q.push_back(base);
            exp_addr_q.push_back(base + ddr_app_pkg::BEAT_OFFSET);
            exp_wdata_q.push_back(req.data[127:0]);
            exp_wdata_q.push_back(req.data[255:128]);
            if (req.write) begin
                shadow[req.addr] = req.data;
                wr_accepted++;
            end else begin
                exp_rsp_q.push_back(expected_line(req.addr));
            end
        end
    end

    // Read responses in request order
    always @(posedge ui_clk) begin
        if (rst && rsp_valid && rsp_ready) begin
            rd_taken++;
            if (exp_rsp_q.size() == 0) begin
                other_errs++;
                $display("Response returned with no read pending");
            end else begin
                check_line("rsp.data", exp_rsp_q.pop_front(), rsp.data);
            end
        end
    end

    initial begin
        while (cycles < TIMEOUT) begin
            @(posedge ui_clk);
            cycles++;
        end
        other_errs++;
        $display("Timeout, run did not finish within %0d cycles", TIMEOUT);
        finish_run();
    end

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin
        rst       = 1'b0;
        req       = '0;
        req_valid = 1'b0;
        rsp_ready = 1'b0;
        csr       = '0;
        csr_valid = 1'b0;
        rdy_stall = 1'b0;
        wdf_stall = 1'b0;
        rd_lat    = '0;
        repeat (3) @(posedge ui_clk);
        rst <= 1'b1;
        @(posedge ui_clk);
        // Status follows calibration
        csr_access(1'b0, cpu_line_pkg::CSR_STATUS, '0, val);
        check_csr("csr_rdata STATUS", 32'd0, val);
        while (!init_calib_complete) @(posedge ui_clk);
        csr_access(1'b0, cpu_line_pkg::CSR_STATUS, '0, val);
        check_csr("csr_rdata STATUS", 32'd1, val);
        // Write held until enable is set
        fork
            send_req(1'b1, 22'd5, rand_bits(256));
            begin
                repeat (20) @(posedge ui_clk);
                csr_access(1'b1, cpu_line_pkg::CSR_CTRL, 32'd1, val);
                ctrl_on = 1'b1;
            end
        join
        send_req(1'b0, 22'd5, '0);
        send_req(1'b0, 22'd7, '0);
        for (int i = 0; i < N_RAND; i++) begin
            repeat (rand_bits(2)) @(posedge ui_clk);
            is_wr = (rand_bits(1) != 0);
            line  = {6'h2a, 12'h000, 4'(rand_bits(4))};
            send_req(is_wr, line, is_wr ? rand_bits(256) : '0);
        end
        // Last request leaves idle before the drain wait
        @(posedge ui_clk);
        while (exp_rsp_q.size() != 0 || !req_ready) @(posedge ui_clk);
        if (exp_addr_q.size() != 0) begin
            other_errs++;
            $display("Accepted request did not issue all of its commands");
        end
        csr_access(1'b0, cpu_line_pkg::CSR_WR_LINES, '0, val);
        check_csr("csr_rdata WR_LINES", cpu_line_pkg::csr_data_t'(wr_accepted), val);
        csr_access(1'b0, cpu_line_pkg::CSR_RD_LINES, '0, val);
        check_csr("csr_rdata RD_LINES", cpu_line_pkg::csr_data_t'(rd_taken), val);
        csr_access(1'b0, cpu_line_pkg::CSR_CTRL, '0, val);
        check_csr("csr_rdata CTRL", 32'd1, val);
        finish_run();
    end

endmodule

// File: tests/app_mem_model.sv
// Behavioral DDR2 app memory
`timescale 1ns/1ps

module app_mem_model #(
    parameter int CALIB_DELAY = 40
) (
    input  logic                   ui_clk,
    input  logic                   rst,
    input  ddr_app_pkg::app_req_t  app_cmd_req,
    input  logic                   app_en,
    output logic                   app_rdy,
    input  ddr_app_pkg::app_data_t app_wdf_data,
    input  logic                   app_wdf_wren,
    input  logic                   app_wdf_end,
    output logic                   app_wdf_rdy,
    output ddr_app_pkg::app_data_t app_rd_data,
    output logic                   app_rd_data_valid,
    output logic                   init_calib_complete,
    // Stall and latency controls from the testbench LFSR
    input  logic                   rdy_stall,
    input  logic                   wdf_stall,
    input  logic [2:0]             rd_lat
);

    ddr_app_pkg::app_data_t mem [ddr_app_pkg::app_addr_t];
    ddr_app_pkg::app_addr_t rd_addr_q [$];
    int                     rd_due_q [$];
    int                     cyc;
    int                     due;
    int                     last_due;
    int                     calib_cnt;

    // Unwritten locations read as zero
    function automatic ddr_app_pkg::app_data_t read_beat(input ddr_app_pkg::app_addr_t a);
        return mem.exists(a) ? mem[a] : '0;
    endfunction

    assign app_rdy     = init_calib_complete && !rdy_stall;
    assign app_wdf_rdy = init_calib_complete && !wdf_stall;

    always @(posedge ui_clk) begin
        if (!rst) begin
            init_calib_complete <= 1'b0;
            app_rd_data_valid   <= 1'b0;
            app_rd_data         <= '0;
            calib_cnt = 0;
            cyc       = 0;
            last_due  = 0;
            rd_addr_q.delete();
            rd_due_q.delete();
        end else begin
            if (calib_cnt < CALIB_DELAY) begin
                calib_cnt++;
            end else begin
                init_calib_complete <= 1'b1;
            end
            // At most one beat per cycle, in command order
            app_rd_data_valid <= 1'b0;
            if (rd_due_q.size() != 0 && rd_due_q[0] <= cyc) begin
                void'(rd_due_q.pop_front());
                app_rd_data       <= read_beat(rd_addr_q.pop_front());
                app_rd_data_valid <= 1'b1;
            end
            if (app_en && app_rdy && app_cmd_req.cmd == ddr_app_pkg::APP_CMD_READ) begin
                due = cyc + 2 + rd_lat;
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                rd_addr_q.push_back(app_cmd_req.addr);
                rd_due_q.push_back(due);
            end
            // Command and data of a write beat taken together
            if (app_en && app_rdy && app_wdf_wren && app_wdf_end && app_wdf_rdy &&
                app_cmd_req.cmd == ddr_app_pkg::APP_CMD_WRITE) begin
                mem[app_cmd_req.addr] = app_wdf_data;
            end
            cyc++;
        end
    end

endmodule

// File: design/ddr_line_bridge.sv
// Cache line to DDR2 app bridge
`timescale 1ns/1ps

module ddr_line_bridge #(
    parameter int CNT_W = 16
) (
    input  logic                    ui_clk,
    input  logic                    rst,
    // Processor line port
    input  cpu_line_pkg::line_req_t req,
    input  logic                    req_valid,
    output logic                    req_ready,
    output cpu_line_pkg::line_rsp_t rsp,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    // Register port
    input  cpu_line_pkg::csr_req_t  csr,
    input  logic                    csr_valid,
    output logic                    csr_ready,
    output cpu_line_pkg::csr_data_t csr_rdata,
    output logic                    csr_rvalid,
    // Controller app interface, write mask held at zero outside this block
    output ddr_app_pkg::app_req_t   app_cmd_req,
    output logic                    app_en,
    input  logic                    app_rdy,
    output ddr_app_pkg::app_data_t  app_wdf_data,
    output logic                    app_wdf_wren,
    output logic                    app_wdf_end,
    input  logic                    app_wdf_rdy,
    input  ddr_app_pkg::app_data_t  app_rd_data,
    input  logic                    app_rd_data_valid,
    input  logic                    init_calib_complete
);

    logic rd_expect;
    logic rsp_busy;
    logic wr_done;
    logic rd_done;
    logic enable;

    line_sequencer u_seq (
        .ui_clk              (ui_clk),
        .rst                 (rst),
        .req                 (req),
        .req_valid           (req_valid),
        .req_ready           (req_ready),
        .enable              (enable),
        .init_calib_complete (init_calib_complete),
        .rsp_busy            (rsp_busy),
        .app_cmd_req         (app_cmd_req),
        .app_en              (app_en),
        .app_rdy             (app_rdy),
        .app_wdf_data        (app_wdf_data),
        .app_wdf_wren        (app_wdf_wren),
        .app_wdf_end         (app_wdf_end),
        .app_wdf_rdy         (app_wdf_rdy),
        .rd_expect           (rd_expect),
        .wr_done             (wr_done)
    );

    read_assembler u_asm (
        .ui_clk            (ui_clk),
        .rst               (rst),
        .rd_expect         (rd_expect),
        .app_rd_data       (app_rd_data),
        .app_rd_data_valid (app_rd_data_valid),
        .rsp               (rsp),
        .rsp_valid         (rsp_valid),
        .rsp_ready         (rsp_ready),
        .rsp_busy          (rsp_busy),
        .rd_done           (rd_done)
    );

    bridge_csr #(
        .CNT_W (CNT_W)
    ) u_csr (
        .ui_clk              (ui_clk),
        .rst                 (rst),
        .csr                 (csr),
        .csr_valid           (csr_valid),
        .csr_ready           (csr_ready),
        .csr_rdata           (csr_rdata),
        .csr_rvalid          (csr_rvalid),
        .init_calib_complete (init_calib_complete),
        .wr_done             (wr_done),
        .rd_done             (rd_done),
        .enable              (enable)
    );

endmodule

// File: design/bridge_csr.sv
// Bridge control and status registers
`timescale 1ns/1ps

module bridge_csr #(
    parameter int CNT_W = 16
) (
    input  logic                    ui_clk,
    input  logic                    rst,
    // Register port
    input  cpu_line_pkg::csr_req_t  csr,
    input  logic                    csr_valid,
    output logic                    csr_ready,
    output cpu_line_pkg::csr_data_t csr_rdata,
    output logic                    csr_rvalid,
    // Status and events
    input  logic                    init_calib_complete,
    input  logic                    wr_done,
    input  logic                    rd_done,
    output logic                    enable
);

    logic [CNT_W-1:0] wr_cnt;
    logic [CNT_W-1:0] rd_cnt;
    logic             csr_wr;
    logic             csr_rd;

    // Counter stops at all ones
    function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] val);
        return (&val) ? val : val + 1'b1;
    endfunction

    assign csr_ready = 1'b1;
    assign csr_wr    = csr_valid && csr.write;
    assign csr_rd    = csr_valid && !csr.write;

    // ------------------------------
    // Control state
    // ------------------------------

    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            enable     <= 1'b0;
            wr_cnt     <= '0;
            rd_cnt     <= '0;
            csr_rvalid <= 1'b0;
        end else begin
            // Only CTRL is writable
            if (csr_wr && csr.addr == cpu_line_pkg::CSR_CTRL) begin
                enable <= csr.data[0];
            end
            if (wr_done) begin
                wr_cnt <= sat_inc(wr_cnt);
            end
            if (rd_done) begin
                rd_cnt <= sat_inc(rd_cnt);
            end
            csr_rvalid <= csr_rd;
        end
    end

    // ------------------------------
    // Read data
    // ------------------------------

    always_ff @(posedge ui_clk) begin
        if (csr_rd) begin
            case (csr.addr)
                cpu_line_pkg::CSR_CTRL:     csr_rdata <= {31'd0, enable};
                cpu_line_pkg::CSR_STATUS:   csr_rdata <= {31'd0, init_calib_complete};
                cpu_line_pkg::CSR_WR_LINES: csr_rdata <= cpu_line_pkg::csr_data_t'(wr_cnt);
                default:                    csr_rdata <= cpu_line_pkg::csr_data_t'(rd_cnt);
            endcase
        end
    end

endmodule

// File: design/read_assembler.sv
// Read beat assembler
`timescale 1ns/1ps

module read_assembler (
    input  logic                    ui_clk,
    input  logic                    rst,
    input  logic                    rd_expect,
    // Read beats from the controller
    input  ddr_app_pkg::app_data_t  app_rd_data,
    input  logic                    app_rd_data_valid,
    // Processor response side
    output cpu_line_pkg::line_rsp_t rsp,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    // To sequencer and registers
    output logic                    rsp_busy,
    output logic                    rd_done
);

    typedef enum logic [1:0] {
        EMPTY,
        WAIT_LO,
        WAIT_HI,
        FULL
    } state_t;

    state_t                   state;
    cpu_line_pkg::line_data_t line_q;

    assign rsp.data  = line_q;
    assign rsp_valid = (state == FULL);
    assign rsp_busy  = (state != EMPTY);
    assign rd_done   = rsp_valid && rsp_ready;

    // Beats land in line order
    always_ff @(posedge ui_clk) begin
        if (app_rd_data_valid && state == WAIT_LO) begin
            line_q[127:0] <= app_rd_data;
        end
        if (app_rd_data_valid && state == WAIT_HI) begin
            line_q[255:128] <= app_rd_data;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            state <= EMPTY;
        end else begin
            case (state)
                EMPTY:   if (rd_expect) state <= WAIT_LO;
                WAIT_LO: if (app_rd_data_valid) state <= WAIT_HI;
                WAIT_HI: if (app_rd_data_valid) state <= FULL;
                FULL:    if (rsp_ready) state <= EMPTY;
                default: state <= EMPTY;
            endcase
        end
    end

    // Controller returns beats only for an armed read
    a_beat_when_armed: assert property (@(posedge ui_clk) disable iff (!rst)
        app_rd_data_valid |-> (state == WAIT_LO || state == WAIT_HI));

    // Sequencer holds off new reads until the response is taken
    a_arm_when_empty: assert property (@(posedge ui_clk) disable iff (!rst)
        rd_expect |-> state == EMPTY);

endmodule

// File: design/line_sequencer.sv
// Line request sequencer
`timescale 1ns/1ps

module line_sequencer (
    input  logic                    ui_clk,
    input  logic                    rst,
    // Processor request side
    input  cpu_line_pkg::line_req_t req,
    input  logic                    req_valid,
    output logic                    req_ready,
    // Steering
    input  logic                    enable,
    input  logic                    init_calib_complete,
    input  logic                    rsp_busy,
    // App command and write channels
    output ddr_app_pkg::app_req_t   app_cmd_req,
    output logic                    app_en,
    input  logic                    app_rdy,
    output ddr_app_pkg::app_data_t  app_wdf_data,
    output logic                    app_wdf_wren,
    output logic                    app_wdf_end,
    input  logic                    app_wdf_rdy,
    // Side pulses
    output logic                    rd_expect,
    output logic                    wr_done
);

    typedef enum logic [2:0] {
        IDLE,
        WR_BEAT0,
        WR_BEAT1,
        RD_CMD0,
        RD_CMD1
    } state_t;

    state_t                  state;
    cpu_line_pkg::line_req_t req_q;
    ddr_app_pkg::app_addr_t  base_addr;
    logic                    accept;
    logic                    is_wr;
    logic                    is_hi;
    logic                    beat_go;

    // ------------------------------
    // Request handshake
    // ------------------------------

    assign req_ready = (state == IDLE) && enable && init_calib_complete && !rsp_busy;
    assign accept    = req_valid && req_ready;

    // Arms the read assembler on the accepting edge
    assign rd_expect = accept && !req.write;

    always_ff @(posedge ui_clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // ------------------------------
    // Beat decode
    // ------------------------------

    assign is_wr = (state == WR_BEAT0) || (state == WR_BEAT1);
    assign is_hi = (state == WR_BEAT1) || (state == RD_CMD1);

    // Write beats wait on both channels, read commands only on app_rdy
    assign beat_go = app_rdy && (app_wdf_rdy || !is_wr);
    assign wr_done = (state == WR_BEAT1) && beat_go;

    // Beat 0 address of the latched line
    assign base_addr = {req_q.addr, 5'd0};

    always_comb begin
        app_cmd_req.cmd  = is_wr ? ddr_app_pkg::APP_CMD_WRITE : ddr_app_pkg::APP_CMD_READ;
        app_cmd_req.addr = is_hi ? base_addr + ddr_app_pkg::BEAT_OFFSET : base_addr;
    end

    assign app_en       = (state != IDLE);
    assign app_wdf_wren = is_wr;
    assign app_wdf_end  = is_wr;
    // Low half first, high half on beat 1
    assign app_wdf_data = is_hi ? req_q.data[255:128] : req_q.data[127:0];

    // ------------------------------
    // State machine
    // ------------------------------

    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= req.write ? WR_BEAT0 : RD_CMD0;
                    end
                end
                WR_BEAT0: begin
                    if (beat_go) begin
                        state <= WR_BEAT1;
                    end
                end
                RD_CMD0: begin
                    if (beat_go) begin
                        state <= RD_CMD1;
                    end
                end
                WR_BEAT1, RD_CMD1: begin
                    if (beat_go) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------

    // Commands start only the cycle after a request was taken
    a_en_after_accept: assert property (@(posedge ui_clk) disable iff (!rst)
        $rose(app_en) |-> $past(accept));

    // A stalled write beat keeps its state, address and data
    a_wr_beat_held: assert property (@(posedge ui_clk) disable iff (!rst)
        app_wdf_wren && !beat_go |=>
            app_wdf_wren && $stable(state) && $stable(app_cmd_req) && $stable(app_wdf_data));

endmodule

// File: design/ddr_app_pkg.sv
// DDR2 controller app interface types
package ddr_app_pkg;

    // ------------------------------
    // Address and data
    // ------------------------------

    typedef logic [26:0] app_addr_t;

    // One full burst per beat
    typedef logic [127:0] app_data_t;

    // App address step from the low half of a line to the high half
    localparam app_addr_t BEAT_OFFSET = 27'd16;

    // ------------------------------
    // Commands
    // ------------------------------

    typedef logic [2:0] app_cmd_t;

    localparam app_cmd_t APP_CMD_WRITE = 3'b000;
    localparam app_cmd_t APP_CMD_READ  = 3'b001;

    // Command channel payload, qualified by app_en
    typedef struct packed {
        app_cmd_t  cmd;
        app_addr_t addr;
    } app_req_t;

    // Read beat with its valid flag
    typedef struct packed {
        logic      valid;
        app_data_t data;
    } app_rd_beat_t;

endpackage

// File: design/cpu_line_pkg.sv
// Processor line port types
package cpu_line_pkg;

    // ------------------------------
    // Line request and response
    // ------------------------------

    // Line index, byte address divided by 32
    typedef logic [21:0] line_addr_t;
    typedef logic [255:0] line_data_t;

    typedef struct packed {
        logic       write;
        line_addr_t addr;
        line_data_t data;
    } line_req_t;

    typedef struct packed {
        line_data_t data;
    } line_rsp_t;

    // ------------------------------
    // Register port
    // ------------------------------

    typedef logic [1:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;

    typedef struct packed {
        logic      write;
        csr_addr_t addr;
        csr_data_t data;
    } csr_req_t;

    // Register map
    localparam csr_addr_t CSR_CTRL     = 2'd0;
    localparam csr_addr_t CSR_STATUS   = 2'd1;
    localparam csr_addr_t CSR_WR_LINES = 2'd2;
    localparam csr_addr_t CSR_RD_LINES = 2'd3;

endpackage
